/* verilog/rs_syndrome_pkg.sv */
/*
 * GF(2^8) field constants, symbol and control types,
 * top-level parameter defaults and the alpha-power multiplier
 */
package rs_syndrome_pkg;

   // ------------------------------
   // field definition
   // ------------------------------
   localparam int unsigned       SYMBOL_W    = 8;
   localparam logic [SYMBOL_W:0] FIELD_POLY  = 9'h187;  // x^8 + x^7 + x^2 + x + 1
   localparam int unsigned       FIELD_ORDER = 255;     // alpha^255 = 1

   // ------------------------------
   // top-level defaults
   // ------------------------------
   localparam int DEFAULT_NUM_SYNDROMES = 16;
   localparam int DEFAULT_CODEWORD_LEN  = 208;
   localparam int DEFAULT_RESULT_DEPTH  = 2;
   localparam int DEFAULT_INIT_CREDITS  = 2;

   // ------------------------------
   // types
   // ------------------------------
   typedef logic [SYMBOL_W-1:0] symbol_t;

   // one symbol as classified by the framer
   typedef struct packed {
      logic    valid;  // symbol belongs to a frame
      logic    first;  // sync symbol, reloads accumulators
      symbol_t data;
   } symbol_ctl_t;

   // ------------------------------
   // value * alpha^exponent
   // ------------------------------
   // Each step multiplies by alpha (a left shift) and folds the x^8 term
   // back in with the field polynomial. The exponent is reduced modulo the
   // multiplicative group order first, so any exponent is accepted.
   function automatic symbol_t gf_mul_alpha_pow(input symbol_t     value,
                                                input int unsigned exponent);
      logic [SYMBOL_W:0] acc;
      int unsigned       steps;

      acc   = {1'b0, value};
      steps = exponent % FIELD_ORDER;
      for (int unsigned k = 0; k < steps; k++) begin
         acc = {acc[SYMBOL_W-1:0], 1'b0};  // times alpha
         if (acc[SYMBOL_W]) begin
            acc = acc ^ FIELD_POLY;         // clears bit 8 as well
         end
      end
      return acc[SYMBOL_W-1:0];
   endfunction

endpackage

/* verilog/rs_symbol_framer.sv */
/*
 * Decode stage: codeword position counter, symbol
 * classification and the registered frame-done pulse
 */
module rs_symbol_framer #(
   parameter int CODEWORD_LEN = rs_syndrome_pkg::DEFAULT_CODEWORD_LEN
) (
   input  logic                         CLK,
   input  logic                         RESET,
   input  logic                         enable,
   input  logic                         sync,
   input  rs_syndrome_pkg::symbol_t     data_in,
   output rs_syndrome_pkg::symbol_ctl_t sym,
   output logic                         frame_done
);

   localparam int CNT_W = $clog2(CODEWORD_LEN + 1);

   logic [CNT_W-1:0] count;     // 0 = idle, 1..CODEWORD_LEN = symbols taken
   logic             in_frame;
   logic             last_sym;

   assign in_frame = (count != '0) && (count != CNT_W'(CODEWORD_LEN));
   assign last_sym = enable && !sync && (count == CNT_W'(CODEWORD_LEN - 1));

   // ------------------------------
   // position counter
   // ------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         count <= '0;
      end else if (enable) begin
         if (sync) begin
            count <= CNT_W'(1);            // sync restarts any frame
         end else if (in_frame) begin
            count <= count + CNT_W'(1);
         end else begin
            count <= '0;                   // idle, or one past the last symbol
         end
      end
   end

   // classification follows the inputs in the same cycle
   always_comb begin
      sym.valid = enable && (sync || in_frame);
      sym.first = enable && sync;
      sym.data  = data_in;
   end

   // high for the one cycle after the last symbol is absorbed
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         frame_done <= 1'b0;
      end else begin
         frame_done <= last_sym;
      end
   end

endmodule

/* verilog/rs_syndrome_bank.sv */
/*
 * Execute stage: one Horner accumulator per syndrome,
 * S_i <- S_i * alpha^i + symbol
 */
module rs_syndrome_bank #(
   parameter int NUM_SYNDROMES = rs_syndrome_pkg::DEFAULT_NUM_SYNDROMES
) (
   input  logic                                         CLK,
   input  logic                                         RESET,
   input  rs_syndrome_pkg::symbol_ctl_t                 sym,
   output rs_syndrome_pkg::symbol_t [NUM_SYNDROMES-1:0] syndromes
);

   import rs_syndrome_pkg::*;

   // ------------------------------
   // accumulators
   // ------------------------------
   for (genvar i = 0; i < NUM_SYNDROMES; i++) begin : g_acc
      symbol_t acc;
      symbol_t acc_scaled;

      // constant exponent per lane, folds to a fixed XOR network
      assign acc_scaled = gf_mul_alpha_pow(acc, i);

      always_ff @(posedge CLK or negedge RESET) begin
         if (!RESET) begin
            acc <= '0;
         end else if (sym.valid) begin
            if (sym.first) begin
               acc <= sym.data;               // start of codeword
            end else begin
               acc <= sym.data ^ acc_scaled;  // Horner step
            end
         end
      end

      assign syndromes[i] = acc;              // element 0 is S_0
   end

endmodule

/* verilog/rs_syndrome_result.sv */
/*
 * Result stage: syndrome-set queue, credit counter for the
 * downstream consumer and the sticky overflow flag
 */
module rs_syndrome_result #(
   parameter int NUM_SYNDROMES = rs_syndrome_pkg::DEFAULT_NUM_SYNDROMES,
   parameter int RESULT_DEPTH  = rs_syndrome_pkg::DEFAULT_RESULT_DEPTH,
   parameter int INIT_CREDITS  = rs_syndrome_pkg::DEFAULT_INIT_CREDITS
) (
   input  logic                                         CLK,
   input  logic                                         RESET,
   input  logic                                         frame_done,
   input  rs_syndrome_pkg::symbol_t [NUM_SYNDROMES-1:0] syndromes,
   input  logic                                         credit_return,
   output logic                                         syn_valid,
   output rs_syndrome_pkg::symbol_t [NUM_SYNDROMES-1:0] syn_set,
   output logic                                         overflow
);

   import rs_syndrome_pkg::*;

   localparam int PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
   localparam int OCC_W = $clog2(RESULT_DEPTH + 1);
   localparam int CRD_W = (INIT_CREDITS > 0) ? $clog2(INIT_CREDITS + 1) : 1;

   symbol_t [NUM_SYNDROMES-1:0] queue_mem [RESULT_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [OCC_W-1:0] occupancy;
   logic [CRD_W-1:0] credit_cnt;   // sets the consumer can still take
   logic             q_full;
   logic             q_empty;
   logic             push;
   logic             send;

   // circular pointer advance
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(RESULT_DEPTH - 1)) begin
         return '0;
      end
      return ptr + PTR_W'(1);
   endfunction

   assign q_full  = (occupancy == OCC_W'(RESULT_DEPTH));
   assign q_empty = (occupancy == '0);
   assign push    = frame_done && !q_full;           // full queue drops the set
   assign send    = !q_empty && (credit_cnt != '0);

   // ------------------------------
   // queue storage and output data
   // ------------------------------
   always_ff @(posedge CLK) begin
      if (push) begin
         queue_mem[wr_ptr] <= syndromes;
      end
      if (send) begin
         syn_set <= queue_mem[rd_ptr];               // head goes out with syn_valid
      end
   end

   // ------------------------------
   // control
   // ------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         occupancy  <= '0;
         credit_cnt <= CRD_W'(INIT_CREDITS);
         syn_valid  <= 1'b0;
         overflow   <= 1'b0;
      end else begin
         syn_valid <= send;
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (send) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, send})
            2'b10:   occupancy <= occupancy + OCC_W'(1);
            2'b01:   occupancy <= occupancy - OCC_W'(1);
            default: occupancy <= occupancy;
         endcase
         case ({send, credit_return})
            2'b10:   credit_cnt <= credit_cnt - CRD_W'(1);
            2'b01:   credit_cnt <= credit_cnt + CRD_W'(1);
            default: credit_cnt <= credit_cnt;   // send and return cancel
         endcase
         if (frame_done && q_full) begin
            overflow <= 1'b1;                     // sticky until reset
         end
      end
   end

endmodule

/* verilog/rs_syndrome_top.sv */
/*
 * Syndrome front end top level: framer, accumulator
 * bank and credit-controlled result queue
 */
module rs_syndrome_top #(
   parameter int NUM_SYNDROMES = rs_syndrome_pkg::DEFAULT_NUM_SYNDROMES,
   parameter int CODEWORD_LEN  = rs_syndrome_pkg::DEFAULT_CODEWORD_LEN,
   parameter int RESULT_DEPTH  = rs_syndrome_pkg::DEFAULT_RESULT_DEPTH,
   parameter int INIT_CREDITS  = rs_syndrome_pkg::DEFAULT_INIT_CREDITS
) (
   input  logic                                         CLK,
   input  logic                                         RESET,
   input  logic                                         enable,
   input  logic                                         sync,
   input  rs_syndrome_pkg::symbol_t                     data_in,
   input  logic                                         credit_return,
   output logic                                         syn_valid,
   output rs_syndrome_pkg::symbol_t [NUM_SYNDROMES-1:0] syn_set,
   output logic                                         overflow
);

   import rs_syndrome_pkg::*;

   symbol_ctl_t                 sym;         // framer to bank
   logic                        frame_done;  // framer to result
   symbol_t [NUM_SYNDROMES-1:0] syndromes;   // bank to result

   rs_symbol_framer #(
      .CODEWORD_LEN (CODEWORD_LEN)
   ) u_framer (
      .CLK        (CLK),
      .RESET      (RESET),
      .enable     (enable),
      .sync       (sync),
      .data_in    (data_in),
      .sym        (sym),
      .frame_done (frame_done)
   );

   rs_syndrome_bank #(
      .NUM_SYNDROMES (NUM_SYNDROMES)
   ) u_bank (
      .CLK       (CLK),
      .RESET     (RESET),
      .sym       (sym),
      .syndromes (syndromes)
   );

   rs_syndrome_result #(
      .NUM_SYNDROMES (NUM_SYNDROMES),
      .RESULT_DEPTH  (RESULT_DEPTH),
      .INIT_CREDITS  (INIT_CREDITS)
   ) u_result (
      .CLK           (CLK),
      .RESET         (RESET),
      .frame_done    (frame_done),
      .syndromes     (syndromes),
      .credit_return (credit_return),
      .syn_valid     (syn_valid),
      .syn_set       (syn_set),
      .overflow      (overflow)
   );

endmodule

/* dv/rs_syndrome_asserts.sv */
/*
 * Protocol checks on the result stage: credit use,
 * credit ceiling, sticky overflow and idle outputs after reset
 */
module rs_syndrome_asserts #(
   parameter int INIT_CREDITS = rs_syndrome_pkg::DEFAULT_INIT_CREDITS,
   parameter int CRD_W        = 2
) (
   input logic             CLK,
   input logic             RESET,
   input logic             syn_valid,
   input logic             overflow,
   input logic [CRD_W-1:0] credit_cnt
);

   timeunit 1ns;
   timeprecision 1ps;

   int violations = 0;  // read by the testbench at the end

   // ------------------------------
   // credit protocol
   // ------------------------------
   a_send_needs_credit : assert property (@(posedge CLK) disable iff (!RESET)
      syn_valid |-> ($past(credit_cnt) != '0))
      else begin
         violations++;
         $error("syn_valid sent while the credit count was zero");
      end

   a_credit_ceiling : assert property (@(posedge CLK) disable iff (!RESET)
      credit_cnt <= CRD_W'(INIT_CREDITS))
      else begin
         violations++;
         $error("credit count above its initial value");
      end

   // ------------------------------
   // flags
   // ------------------------------
   a_overflow_sticky : assert property (@(posedge CLK) disable iff (!RESET)
      overflow |=> overflow)
      else begin
         violations++;
         $error("overflow fell without a reset");
      end

   a_idle_after_reset : assert property (@(posedge CLK)
      $rose(RESET) |-> (!syn_valid && !overflow))
      else begin
         violations++;
         $error("syn_valid or overflow high right after reset");
      end

endmodule

bind rs_syndrome_result rs_syndrome_asserts #(
   .INIT_CREDITS (INIT_CREDITS),
   .CRD_W        (CRD_W)
) u_asserts (
   .CLK        (CLK),
   .RESET      (RESET),
   .syn_valid  (syn_valid),
   .overflow   (overflow),
   .credit_cnt (credit_cnt)
);

/* dv/tb_rs_syndrome.sv */
/*
 * Testbench for the syndrome front end with clock, reset, framed
 * random stimulus, a GF(2^8) reference model and a credit-returning consumer
 */
module tb_rs_syndrome;

   timeunit 1ns;
   timeprecision 1ps;

   import rs_syndrome_pkg::*;

   localparam int NUM_SYN = DEFAULT_NUM_SYNDROMES;
   localparam int LEN     = DEFAULT_CODEWORD_LEN;
   localparam int DEPTH   = DEFAULT_RESULT_DEPTH;
   localparam int CREDITS = DEFAULT_INIT_CREDITS;
   // twice about 13 frames incl. gaps and drains
   localparam int MAX_CYCLES = 2 * 13 * (LEN + 24);
   localparam logic [14:0] REDUCE = 15'h187;  // x^8 + x^7 + x^2 + x + 1

   typedef symbol_t [NUM_SYN-1:0] set_t;

   logic    CLK = 1'b0;
   logic    RESET;
   logic    enable;
   logic    sync;
   symbol_t data_in;
   logic    credit_return = 1'b0;
   logic    syn_valid;
   set_t    syn_set;
   logic    overflow;

   int      seed;
   symbol_t frame_syms [LEN];
   set_t    exp_q [$];         // expected sets in delivery order
   int      exp_rd = 0;        // next set to be delivered
   set_t    exp_head;
   logic    exp_avail = 1'b0;
   int      sets_held = 0;     // sets the consumer has not freed yet
   logic    auto_credit = 1'b0;
   int      error_cnt = 0;
   int      errors_before;
   int      pass_cnt = 0;
   int      fail_cnt = 0;
   int      cycle_cnt = 0;

   rs_syndrome_top #(
      .NUM_SYNDROMES (NUM_SYN),
      .CODEWORD_LEN  (LEN),
      .RESULT_DEPTH  (DEPTH),
      .INIT_CREDITS  (CREDITS)
   ) u_dut (
      .CLK           (CLK),
      .RESET         (RESET),
      .enable        (enable),
      .sync          (sync),
      .data_in       (data_in),
      .credit_return (credit_return),
      .syn_valid     (syn_valid),
      .syn_set       (syn_set),
      .overflow      (overflow)
   );

   always #20 CLK = ~CLK;

   // ------------------------------
   // reference model
   // ------------------------------
   // carry-less product, then fold bits 14..8
   function automatic symbol_t field_mult(input symbol_t a, input symbol_t b);
      logic [14:0] prod;

      prod = '0;
      for (int j = 0; j < 8; j++) begin
         if (b[j]) prod = prod ^ (15'(a) << j);
      end
      for (int k = 14; k >= 8; k--) begin
         if (prod[k]) prod = prod ^ (REDUCE << (k - 8));
      end
      return prod[7:0];
   endfunction

   // Horner over the first n symbols; scale 1 makes S_0 the plain XOR
   function automatic set_t model_set(input int n);
      set_t    s;
      symbol_t scale;

      for (int i = 0; i < NUM_SYN; i++) begin
         scale = 8'h01;
         for (int p = 0; p < i; p++) scale = field_mult(scale, 8'h02);  // alpha^i
         s[i] = '0;
         for (int k = 0; k < n; k++) s[i] = field_mult(s[i], scale) ^ frame_syms[k];
      end
      return s;
   endfunction

   function automatic int pending();
      return exp_q.size() - exp_rd;
   endfunction

   function automatic int total_errors();
      return error_cnt + u_dut.u_result.u_asserts.violations;
   endfunction

   task automatic report_error(input string msg);
      error_cnt++;
      $display("ERROR at %0d ns: %s", $time, msg);
   endtask

   // ------------------------------
   // consumer and checks
   // ------------------------------
   always @(posedge CLK) begin : monitor
      int next_rd;

      next_rd = exp_rd + (syn_valid ? 1 : 0);
      exp_rd    <= next_rd;
      exp_avail <= next_rd < exp_q.size();
      exp_head  <= (next_rd < exp_q.size()) ? exp_q[next_rd] : '0;
      sets_held <= sets_held + (syn_valid ? 1 : 0) - (credit_return ? 1 : 0);
   end

   always @(posedge CLK) begin
      #2;
      credit_return = auto_credit && (sets_held > 0);  // one free per cycle
   end

   a_set_match : assert property (@(posedge CLK) disable iff (!RESET)
      (syn_valid && exp_avail) |-> (syn_set == exp_head))
      else report_error($sformatf("syndrome set %h, expected %h",
                                  $sampled(syn_set), $sampled(exp_head)));

   a_set_expected : assert property (@(posedge CLK) disable iff (!RESET)
      syn_valid |-> exp_avail)
      else report_error("syndrome set delivered with none expected");

   a_consumer_room : assert property (@(posedge CLK) disable iff (!RESET)
      syn_valid |-> (sets_held < CREDITS))
      else report_error("set delivered while the consumer had no room");

   always @(posedge CLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   task automatic drive_cycle(input logic en, input logic sy, input symbol_t d);
      @(posedge CLK);
      #2;
      enable  = en;
      sync    = sy;
      data_in = d;
   endtask

   task automatic fill_random(input int n);
      for (int k = 0; k < n; k++) frame_syms[k] = symbol_t'($random(seed));
   endtask

   // n symbols from frame_syms with sync on the first and random idle gaps after it
   task automatic drive_frame(input int n, input int gap_pct);
      for (int k = 0; k < n; k++) begin
         while (k > 0 && int'({$random(seed)} % 32'd100) < gap_pct) begin
            drive_cycle(1'b0, 1'b0, symbol_t'($random(seed)));
         end
         drive_cycle(1'b1, k == 0, frame_syms[k]);
      end
      drive_cycle(1'b0, 1'b0, '0);  // last symbol taken here
   endtask

   task automatic wait_until_drained();
      while (pending() != 0 || sets_held != 0) begin
         @(posedge CLK);
         #2;
      end
      repeat (4) @(posedge CLK);   // room for a stray set
      #2;
   endtask

   task automatic start_test();
      errors_before = total_errors();
   endtask

   task automatic end_test(input string name);
      if (total_errors() == errors_before) begin
         pass_cnt++;
         $display("PASS  %s", name);
      end else begin
         fail_cnt++;
         $display("FAIL  %s", name);
      end
   endtask

   // ------------------------------
   // tests
   // ------------------------------
   initial begin
      seed        = 24561;
      RESET       = 1'b0;
      enable      = 1'b0;
      sync        = 1'b0;
      data_in     = '0;
      auto_credit = 1'b1;
      repeat (2) @(posedge CLK);
      #2 RESET = 1'b1;

      start_test();
      assert (!syn_valid && !overflow) else report_error("outputs not idle after reset");
      fill_random(LEN);
      drive_frame(LEN, 0);
      exp_q.push_back(model_set(LEN));
      wait_until_drained();
      end_test("random frame");

      start_test();
      fill_random(LEN);
      drive_frame(LEN, 25);
      exp_q.push_back(model_set(LEN));
      drive_frame(LEN, 0);                   // same symbols without gaps
      exp_q.push_back(model_set(LEN));
      wait_until_drained();
      end_test("gaps in enable");

      start_test();
      fill_random(LEN);
      drive_frame(LEN / 4, 0);               // cut short by the next sync
      fill_random(LEN);
      drive_frame(LEN, 0);
      exp_q.push_back(model_set(LEN));
      wait_until_drained();
      end_test("sync restart");

      start_test();
      auto_credit = 1'b0;
      for (int f = 0; f < 3; f++) begin
         fill_random(LEN);
         drive_frame(LEN, 0);
         exp_q.push_back(model_set(LEN));
      end
      repeat (8) @(posedge CLK);
      #2;
      assert (pending() == 1) else report_error("third set not held back by credits");
      auto_credit = 1'b1;
      wait_until_drained();
      assert (!overflow) else report_error("overflow set with room in the queue");
      end_test("back-pressure");

      start_test();
      auto_credit = 1'b0;
      for (int f = 0; f < CREDITS + DEPTH + 1; f++) begin
         fill_random(LEN);
         drive_frame(LEN, 0);
         if (f < CREDITS + DEPTH) exp_q.push_back(model_set(LEN));  // last one is lost
      end
      repeat (8) @(posedge CLK);
      #2;
      assert (overflow) else report_error("overflow low after a dropped set");
      assert (pending() == DEPTH) else report_error("queued set count wrong");
      auto_credit = 1'b1;
      wait_until_drained();
      assert (overflow) else report_error("overflow fell after credits returned");
      end_test("overflow");

      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && total_errors() == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
verilog/rs_syndrome_pkg.sv
verilog/rs_symbol_framer.sv
verilog/rs_syndrome_bank.sv
verilog/rs_syndrome_result.sv
verilog/rs_syndrome_top.sv
dv/rs_syndrome_asserts.sv
dv/tb_rs_syndrome.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_rs_syndrome
FLIST     := flist.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
